// ==== build.f ====
obstacle_pkg.sv
laser_obstacle.sv
block_obstacle.sv
obstacle_mixer.sv
obstacle_top.sv
tb_obstacle_assert.sv
tb_obstacle.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_obstacle
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_obstacle.sv ====
`timescale 1ns/1ns

module tb_obstacle import obstacle_pkg::*; ();

    typedef struct packed {
        ctrl_t       ctrl;
        logic        start;
        logic [15:0] frames;       // frame_start pixels before the probe
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic [11:0] rgb;
        logic [11:0] player_x;
        logic [11:0] player_y;
    } step_t;

    localparam ctrl_t PLAY = 2'b10;
    localparam ctrl_t STOP = 2'b00;
    localparam ctrl_t MENU = 2'b11;
    localparam int SPAWN = int'(LASER_SPAWN_FRAMES);
    localparam int MAX_HALF = int'(LASER_MAX_HALF);
    localparam int VISIT = SPAWN + MAX_HALF + int'(LASER_GAP_FRAMES);   // frames per beam

    logic pclk;
    logic rst;
    pix_t pix_in;
    ctrl_t ctrl;
    logic start;
    logic [11:0] player_x;
    logic [11:0] player_y;
    pix_t pix_out;
    hit_t hit;
    logic working;
    logic done;

    step_t steps[$];
    integer seed;
    int cycle_cnt = 0;
    int cycle_limit = 0;
    int done_total = 0;

    // reference model state
    logic laser_on;
    logic block_on;
    logic exp_done;
    int lf;                        // frames since the laser started
    int btop;

    obstacle_top i_dut (
        .pclk     (pclk),
        .rst      (rst),
        .pix_in   (pix_in),
        .ctrl     (ctrl),
        .start    (start),
        .player_x (player_x),
        .player_y (player_y),
        .pix_out  (pix_out),
        .hit      (hit),
        .working  (working),
        .done     (done)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("simulation did not finish within %0d clock cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(negedge pclk) begin
        if (done === 1'b1) done_total <= done_total + 1;   // mid cycle, outputs settled
    end

    ////////////////////
    // compare tasks

    task automatic check_pix(input pix_t got, input pix_t exp);
        if (got !== exp) begin
            $display("Error: %0t ns pix_out %0d/%0d/%h/%b, expected %0d/%0d/%h/%b", $time,
                     got.hcount, got.vcount, got.rgb, got.frame_start,
                     exp.hcount, exp.vcount, exp.rgb, exp.frame_start);
            $display("TB FAILED");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_hit(input hit_t got, input hit_t exp);
        if (got !== exp) begin
            $display("Error: %0t ns hit %b/%0d/%0d/%0d, expected %b/%0d/%0d/%0d", $time,
                     got.valid, got.kind, got.x, got.y, exp.valid, exp.kind, exp.x, exp.y);
            $display("TB FAILED");
            $fatal(1, "hit mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %0t ns %s is %b, expected %b", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    ////////////////////
    // reference model

    function automatic logic laser_covers(input logic [11:0] h, input logic [11:0] v);
        int w;
        int half;
        int x;
        w = lf % VISIT;
        half = (w <= SPAWN) ? 0 : w - SPAWN;
        if (half > MAX_HALF) half = MAX_HALF;
        case (lf / VISIT)
            0, 5: x = int'(LASER_LEFT_X);
            1, 4: x = int'(LASER_MIDDLE_X);
            default: x = int'(LASER_RIGHT_X);
        endcase
        return laser_on && int'(h) >= x - half && int'(h) <= x + 1 + half
            && v >= LASER_TOP && v <= LASER_BOTTOM;
    endfunction

    function automatic logic block_covers(input logic [11:0] h, input logic [11:0] v);
        return block_on && int'(h) >= int'(BLOCK_X) && int'(h) < int'(BLOCK_X + BLOCK_SIZE)
            && int'(v) >= btop && int'(v) < btop + int'(BLOCK_SIZE);
    endfunction

    task automatic model_control(input step_t s);
        if (s.ctrl.menu || !s.ctrl.play) begin
            laser_on = 1'b0;
            block_on = 1'b0;
        end else if (s.start) begin
            if (!laser_on) begin
                laser_on = 1'b1;
                lf = 0;
            end
            if (!block_on) begin
                block_on = 1'b1;
                btop = int'(BLOCK_TOP);
            end
        end
    endtask

    task automatic model_frame();
        if (laser_on) begin
            lf++;
            if (lf == 6 * VISIT) begin   // six visits, then back to idle
                laser_on = 1'b0;
                exp_done = 1'b1;
            end
        end
        if (block_on) begin
            btop = btop + int'(BLOCK_STEP);
            if (btop > int'(BLOCK_BOTTOM)) btop = int'(BLOCK_TOP);
        end
    endtask

    task automatic next_cycle();
        @(posedge pclk);
        #1;
    endtask

    task automatic add_step(input ctrl_t c, input logic st, input int frames,
                            input int h, input int v, input int px, input int py);
        step_t s;
        s.ctrl = c;
        s.start = st;
        s.frames = 16'(frames);
        s.hcount = 12'(h);
        s.vcount = 12'(v);
        s.rgb = 12'($random(seed));
        s.player_x = 12'(px);
        s.player_y = 12'(py);
        steps.push_back(s);
    endtask

    ////////////////////
    // stimulus table

    task automatic build_table();
        add_step(PLAY, 0, 0, 411, 400, 400, 390);    // idle, nothing drawn
        add_step(PLAY, 0, 3, 708, 110, 700, 100);
        add_step(STOP, 0, 2, 611, 500, 0, 0);
        add_step(PLAY, 1, 0, 411, 400, 0, 0);        // start, thin left beam
        add_step(PLAY, 0, 0, 412, 400, 0, 0);
        add_step(PLAY, 0, 0, 410, 400, 0, 0);
        add_step(PLAY, 0, 0, 411, 316, 0, 0);
        add_step(PLAY, 0, 0, 411, 617, 0, 0);
        add_step(PLAY, 0, 0, 411, 618, 0, 0);
        add_step(PLAY, 0, 0, 715, 115, 0, 0);        // block at its top row
        add_step(PLAY, 0, 0, 716, 100, 0, 0);
        add_step(PLAY, 0, 7, 405, 400, 0, 0);        // growth
        add_step(PLAY, 0, 1, 405, 400, 0, 0);
        add_step(PLAY, 0, 0, 404, 400, 0, 0);
        add_step(PLAY, 0, 17, 700, 600, 0, 0);       // block at the bottom, then wrap
        add_step(PLAY, 0, 1, 700, 100, 0, 0);
        add_step(PLAY, 0, 0, 700, 99, 0, 0);
        add_step(PLAY, 0, 10, 511, 400, 500, 390);   // middle beam hits player
        add_step(PLAY, 0, 0, 411, 400, 0, 0);
        add_step(PLAY, 0, 0, 705, 305, 700, 300);    // block hits player
        add_step(PLAY, 0, 0, 511, 400, 520, 390);
        add_step(PLAY, 0, 36, 611, 400, 0, 0);       // right, right, middle, left
        add_step(PLAY, 0, 36, 611, 400, 0, 0);
        add_step(PLAY, 0, 0, 511, 400, 0, 0);
        add_step(PLAY, 0, 36, 511, 400, 0, 0);
        add_step(PLAY, 0, 36, 411, 400, 0, 0);
        add_step(PLAY, 0, 35, 411, 400, 0, 0);
        add_step(PLAY, 0, 1, 411, 400, 0, 0);        // done
        add_step(PLAY, 0, 10, 411, 400, 0, 0);
        add_step(STOP, 0, 0, 700, 100, 0, 0);
        add_step(PLAY, 1, 40, 511, 400, 0, 0);       // abort mid sequence
        add_step(STOP, 0, 5, 511, 400, 0, 0);
        add_step(PLAY, 0, 250, 411, 400, 0, 0);
        add_step(PLAY, 1, 3, 411, 400, 0, 0);
        add_step(MENU, 0, 2, 411, 400, 0, 0);
    endtask

    initial begin
        step_t s;
        pix_t exp_pix;
        hit_t exp_hit;
        logic lcov;
        logic bcov;
        logic in_player;
        int done_mark;
        int total;

        rst = 1'b1;
        ctrl = STOP;
        start = 1'b0;
        player_x = '0;
        player_y = '0;
        pix_in = '0;
        seed = 32'hf5a4_6cd8;
        laser_on = 1'b0;
        block_on = 1'b0;
        exp_done = 1'b0;
        lf = 0;
        btop = int'(BLOCK_TOP);
        build_table();
        total = 3;
        foreach (steps[i]) total += int'(steps[i].frames) + 4;
        cycle_limit = 2 * total;

        repeat (3) next_cycle();
        rst = 1'b0;

        foreach (steps[i]) begin
            s = steps[i];
            done_mark = done_total;
            exp_done = 1'b0;
            ctrl = s.ctrl;
            start = s.start;
            player_x = s.player_x;
            player_y = s.player_y;
            pix_in = '0;
            model_control(s);
            next_cycle();
            start = 1'b0;
            repeat (int'(s.frames)) begin
                pix_in.frame_start = 1'b1;
                model_frame();
                next_cycle();
            end

            // probe pixel
            pix_in.hcount = s.hcount;
            pix_in.vcount = s.vcount;
            pix_in.rgb = s.rgb;
            pix_in.frame_start = 1'b0;
            lcov = laser_covers(s.hcount, s.vcount);
            bcov = block_covers(s.hcount, s.vcount);
            exp_pix = pix_in;
            if (lcov) exp_pix.rgb = LASER_RGB;
            else if (bcov) exp_pix.rgb = BLOCK_RGB;
            in_player = s.hcount >= s.player_x && s.vcount >= s.player_y
                && int'(s.hcount) < int'(s.player_x) + int'(PLAYER_SIZE)
                && int'(s.vcount) < int'(s.player_y) + int'(PLAYER_SIZE);
            exp_hit.valid = (lcov || bcov) && in_player;
            if (!exp_hit.valid) exp_hit.kind = KIND_NONE;
            else if (lcov) exp_hit.kind = KIND_LASER;
            else exp_hit.kind = KIND_BLOCK;
            exp_hit.x = s.hcount;
            exp_hit.y = s.vcount;

            next_cycle();
            pix_in = '0;
            next_cycle();                           // probe now at the outputs
            check_pix(pix_out, exp_pix);
            check_hit(hit, exp_hit);
            check_flag("working", working, laser_on || block_on);
            check_flag("done pulse", done_total != done_mark, exp_done);
        end

        if (i_dut.i_assert.any_err) begin
            $display("protocol assertion failed during the run");
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== tb_obstacle_assert.sv ====
`timescale 1ns/1ns

module tb_obstacle_assert import obstacle_pkg::*; (
    input logic pclk,
    input logic rst,
    input hit_t hit,
    input logic working,
    input logic done
);

    logic done_err = 1'b0;
    logic kind_err = 1'b0;
    logic reset_err = 1'b0;
    logic any_err;

    assign any_err = done_err | kind_err | reset_err;

    // done is a single cycle pulse
    done_pulse: assert property (@(posedge pclk) disable iff (rst) done |=> !done)
    else begin
        $error("done high on two consecutive cycles");
        done_err = 1'b1;
    end

    hit_kind: assert property (@(posedge pclk) disable iff (rst) hit.valid |-> hit.kind != KIND_NONE)
    else begin
        $error("hit valid with no obstacle kind");
        kind_err = 1'b1;
    end

    reset_idle: assert property (@(posedge pclk) rst |=> !working)   // idle right after reset
    else begin
        $error("working high after reset");
        reset_err = 1'b1;
    end

endmodule

bind obstacle_top tb_obstacle_assert i_assert (
    .pclk    (pclk),
    .rst     (rst),
    .hit     (hit),
    .working (working),
    .done    (done)
);

// ==== obstacle_top.sv ====
`timescale 1ns/1ns

module obstacle_top import obstacle_pkg::*; (
    input  logic        pclk,
    input  logic        rst,
    input  pix_t        pix_in,
    input  ctrl_t       ctrl,
    input  logic        start,
    input  logic [11:0] player_x,
    input  logic [11:0] player_y,
    output pix_t        pix_out,
    output hit_t        hit,
    output logic        working,
    output logic        done
);

    pix_t laser_pix;        // pixel delayed to match the covered bits
    logic laser_cov;
    logic block_cov;
    logic laser_active;
    logic block_active;

    laser_obstacle i_laser (
        .pclk         (pclk),
        .rst          (rst),
        .pix_in       (pix_in),
        .ctrl         (ctrl),
        .start        (start),
        .laser_pix    (laser_pix),
        .laser_cov    (laser_cov),
        .laser_active (laser_active),
        .done         (done)
    );

    block_obstacle i_block (
        .pclk         (pclk),
        .rst          (rst),
        .pix_in       (pix_in),
        .ctrl         (ctrl),
        .start        (start),
        .block_cov    (block_cov),
        .block_active (block_active)
    );

    obstacle_mixer i_mixer (
        .pclk         (pclk),
        .rst          (rst),
        .laser_pix    (laser_pix),
        .laser_cov    (laser_cov),
        .block_cov    (block_cov),
        .laser_active (laser_active),
        .block_active (block_active),
        .player_x     (player_x),
        .player_y     (player_y),
        .pix_out      (pix_out),
        .hit          (hit),
        .working      (working)
    );

endmodule

// ==== obstacle_mixer.sv ====
`timescale 1ns/1ns

module obstacle_mixer import obstacle_pkg::*; (
    input  logic        pclk,
    input  logic        rst,
    input  pix_t        laser_pix,
    input  logic        laser_cov,
    input  logic        block_cov,
    input  logic        laser_active,
    input  logic        block_active,
    input  logic [11:0] player_x,
    input  logic [11:0] player_y,
    output pix_t        pix_out,
    output hit_t        hit,
    output logic        working
);

    logic in_player;
    obstacle_kind_t kind;
    pix_t pix_nxt;
    hit_t hit_nxt;

    // player square, compared as an offset from its corner
    always_comb begin
        in_player = (laser_pix.hcount >= player_x)
            && (laser_pix.hcount - player_x < PLAYER_SIZE)
            && (laser_pix.vcount >= player_y)
            && (laser_pix.vcount - player_y < PLAYER_SIZE);
    end

    ////////////////////
    // overlay, laser above block

    always_comb begin
        pix_nxt = laser_pix;
        if (laser_cov) begin
            kind        = KIND_LASER;
            pix_nxt.rgb = LASER_RGB;
        end else if (block_cov) begin
            kind        = KIND_BLOCK;
            pix_nxt.rgb = BLOCK_RGB;
        end else begin
            kind = KIND_NONE;       // background passes through
        end
    end

    always_comb begin
        hit_nxt.valid = (kind != KIND_NONE) && in_player;
        hit_nxt.kind  = hit_nxt.valid ? kind : KIND_NONE;
        hit_nxt.x     = laser_pix.hcount;
        hit_nxt.y     = laser_pix.vcount;
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            pix_out <= '0;
            hit     <= '0;
            working <= 1'b0;
        end else begin
            pix_out <= pix_nxt;
            hit     <= hit_nxt;
            working <= laser_active || block_active;
        end
    end

endmodule

// ==== block_obstacle.sv ====
`timescale 1ns/1ns

module block_obstacle import obstacle_pkg::*; (
    input  logic  pclk,
    input  logic  rst,
    input  pix_t  pix_in,
    input  ctrl_t ctrl,
    input  logic  start,
    output logic  block_cov,
    output logic  block_active
);

    block_state_t state, state_nxt;
    logic [11:0] top, top_nxt;     // top row of the block
    logic [11:0] top_step;
    logic cov_nxt;

    assign block_active = (state == BLOCK_FALL);

    // top never exceeds 600, so the sum stays in 12 bits
    assign top_step = top + BLOCK_STEP;

    ////////////////////
    // fall and wrap

    always_comb begin
        state_nxt = state;
        top_nxt   = top;

        case (state)
            BLOCK_IDLE: begin
                if (start && ctrl.play && !ctrl.menu) begin
                    state_nxt = BLOCK_FALL;
                    top_nxt   = BLOCK_TOP;
                end
            end

            default: begin
                if (ctrl.menu || !ctrl.play) begin
                    state_nxt = BLOCK_IDLE;
                end else if (pix_in.frame_start) begin
                    if (top_step > BLOCK_BOTTOM) begin
                        top_nxt = BLOCK_TOP;        // wrap to the top
                    end else begin
                        top_nxt = top_step;
                    end
                end
            end
        endcase
    end

    ////////////////////
    // coverage

    always_comb begin
        cov_nxt = block_active
            && (pix_in.hcount >= BLOCK_X)
            && (pix_in.hcount < BLOCK_X + BLOCK_SIZE)
            && (pix_in.vcount >= top)
            && (pix_in.vcount < top + BLOCK_SIZE);
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            state     <= BLOCK_IDLE;
            top       <= BLOCK_TOP;
            block_cov <= 1'b0;
        end else begin
            state     <= state_nxt;
            top       <= top_nxt;
            block_cov <= cov_nxt;
        end
    end

endmodule

// ==== laser_obstacle.sv ====
`timescale 1ns/1ns

module laser_obstacle import obstacle_pkg::*; (
    input  logic  pclk,
    input  logic  rst,
    input  pix_t  pix_in,
    input  ctrl_t ctrl,
    input  logic  start,
    output pix_t  laser_pix,
    output logic  laser_cov,
    output logic  laser_active,
    output logic  done
);

    laser_state_t state, state_nxt;
    logic [HALF_W-1:0] half, half_nxt;               // beam growth on each side
    logic [FRAME_CNT_W-1:0] frame_cnt, frame_cnt_nxt;
    logic bounce, bounce_nxt;                        // set once the right beam repeats
    logic done_nxt;
    logic abort;
    logic [11:0] beam_x;
    logic cov_nxt;

    assign laser_active = (state != LASER_IDLE);
    assign abort        = ctrl.menu || !ctrl.play;

    ////////////////////
    // beam position and coverage

    always_comb begin
        case (state)
            LASER_MIDDLE: beam_x = LASER_MIDDLE_X;
            LASER_RIGHT:  beam_x = LASER_RIGHT_X;
            default:      beam_x = LASER_LEFT_X;
        endcase
    end

    always_comb begin
        cov_nxt = laser_active
            && (pix_in.hcount >= beam_x - 12'(half))
            && (pix_in.hcount <= beam_x + 12'd1 + 12'(half))
            && (pix_in.vcount >= LASER_TOP)
            && (pix_in.vcount <= LASER_BOTTOM);
    end

    ////////////////////
    // sequence FSM

    always_comb begin
        state_nxt     = state;
        half_nxt      = half;
        frame_cnt_nxt = frame_cnt;
        bounce_nxt    = bounce;
        done_nxt      = 1'b0;

        case (state)
            LASER_IDLE: begin
                if (start && ctrl.play && !ctrl.menu) begin
                    state_nxt     = LASER_LEFT;
                    half_nxt      = '0;
                    frame_cnt_nxt = '0;
                    bounce_nxt    = 1'b0;
                end
            end

            default: begin
                if (abort) begin
                    state_nxt = LASER_IDLE;                  // no done on abort
                end else if (pix_in.frame_start) begin
                    if (half != LASER_MAX_HALF) begin
                        if (frame_cnt != LASER_SPAWN_FRAMES) begin
                            frame_cnt_nxt = frame_cnt + 1'b1;   // thin beam holds
                        end else begin
                            half_nxt = half + 1'b1;
                            if (half_nxt == LASER_MAX_HALF) begin
                                frame_cnt_nxt = '0;         // full width, start gap
                            end
                        end
                    end else if (frame_cnt != LASER_GAP_FRAMES - 1'b1) begin
                        frame_cnt_nxt = frame_cnt + 1'b1;
                    end else begin
                        // gap over, next beam starts thin
                        half_nxt      = '0;
                        frame_cnt_nxt = '0;
                        case (state)
                            LASER_LEFT: begin
                                if (bounce) begin
                                    state_nxt = LASER_IDLE;
                                    done_nxt  = 1'b1;
                                end else begin
                                    state_nxt = LASER_MIDDLE;
                                end
                            end
                            LASER_MIDDLE: begin
                                state_nxt = bounce ? LASER_LEFT : LASER_RIGHT;
                            end
                            default: begin
                                // right twice, then back
                                state_nxt  = bounce ? LASER_MIDDLE : LASER_RIGHT;
                                bounce_nxt = 1'b1;
                            end
                        endcase
                    end
                end
            end
        endcase
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            state     <= LASER_IDLE;
            half      <= '0;
            frame_cnt <= '0;
            bounce    <= 1'b0;
            done      <= 1'b0;
            laser_cov <= 1'b0;
        end else begin
            state     <= state_nxt;
            half      <= half_nxt;
            frame_cnt <= frame_cnt_nxt;
            bounce    <= bounce_nxt;
            done      <= done_nxt;
            laser_cov <= cov_nxt;
        end
    end

    // pixel travels alongside the covered bit
    always_ff @(posedge pclk) begin
        laser_pix <= pix_in;
    end

endmodule

// ==== obstacle_pkg.sv ====
package obstacle_pkg;

    ////////////////////
    // screen geometry

    localparam logic [11:0] LASER_TOP     = 12'd317;   // inclusive
    localparam logic [11:0] LASER_BOTTOM  = 12'd617;   // inclusive
    localparam logic [11:0] LASER_LEFT_X   = 12'd411;  // left column of each 2 pixel core
    localparam logic [11:0] LASER_MIDDLE_X = 12'd511;
    localparam logic [11:0] LASER_RIGHT_X  = 12'd611;

    localparam logic [11:0] BLOCK_X      = 12'd700;
    localparam logic [11:0] BLOCK_SIZE   = 12'd16;
    localparam logic [11:0] BLOCK_TOP    = 12'd100;    // top row after restart or wrap
    localparam logic [11:0] BLOCK_BOTTOM = 12'd600;    // last allowed top row
    localparam logic [11:0] BLOCK_STEP   = 12'd20;     // rows per frame

    localparam logic [11:0] PLAYER_SIZE = 12'd24;

    ////////////////////
    // obstacle timing, all in frames

    localparam int FRAME_CNT_W = 8;
    localparam int HALF_W      = 6;

    localparam logic [HALF_W-1:0]      LASER_MAX_HALF     = 6'd30;
    localparam logic [FRAME_CNT_W-1:0] LASER_SPAWN_FRAMES = 8'd2;
    localparam logic [FRAME_CNT_W-1:0] LASER_GAP_FRAMES   = 8'd4;

    // colours
    localparam logic [11:0] LASER_RGB = 12'hfff;
    localparam logic [11:0] BLOCK_RGB = 12'hf00;

    ////////////////////
    // types

    typedef enum logic [1:0] {KIND_NONE, KIND_LASER, KIND_BLOCK} obstacle_kind_t;

    typedef enum logic [1:0] {LASER_IDLE, LASER_LEFT, LASER_MIDDLE, LASER_RIGHT} laser_state_t;

    typedef enum logic {BLOCK_IDLE, BLOCK_FALL} block_state_t;

    typedef struct packed {
        logic [11:0] hcount;
        logic [11:0] vcount;
        logic [11:0] rgb;          // background colour on input
        logic        frame_start;
    } pix_t;

    typedef struct packed {
        logic play;
        logic menu;
    } ctrl_t;

    typedef struct packed {
        logic           valid;
        obstacle_kind_t kind;
        logic [11:0]    x;
        logic [11:0]    y;
    } hit_t;

endpackage
